// File: common/apu_bus_if.sv
`timescale 1ns/100ps

interface apu_bus_if;

  logic [15:0] addr;       // cpu write address.
  logic [7:0]  data;
  logic        we;
  logic        cpu_clk_en;
  logic        apu_clk_en;
  logic        quarter_tick; // envelope clock.
  logic        half_tick;    // length counter clock.

  modport frame (
    input  addr, data, we, cpu_clk_en, apu_clk_en,
    output quarter_tick, half_tick
  );

  modport chan (
    input addr, data, we, cpu_clk_en, apu_clk_en, quarter_tick, half_tick
  );

  modport status (input addr, data, we, cpu_clk_en);

endinterface : apu_bus_if

// File: common/apu_consts.svh
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// ------------------------------
// register map
// ------------------------------

`define APU_PULSE0_BASE 16'h4000
`define APU_PULSE1_BASE 16'h4004
`define APU_NOISE_BASE  16'h400C
`define APU_STATUS_ADDR 16'h4015
`define APU_FRAME_ADDR  16'h4017

// APU ticks between two quarter-frame steps.
`define APU_FRAME_STEP 3729

// linear mixer weights.
`define APU_MIX_PULSE_GAIN 512
`define APU_MIX_NOISE_GAIN 256

`endif

// File: common/apu_pkg.sv
package apu_pkg;

  // pulse duty cycle, as high steps out of eight.
  typedef enum logic [1:0] {
    duty_12 = 2'd0,
    duty_25 = 2'd1,
    duty_50 = 2'd2,
    duty_75 = 2'd3
  } duty_e;

  // frame sequencer mode, from bit 7 of 0x4017.
  typedef enum logic {
    mode_4step = 1'b0,
    mode_5step = 1'b1
  } frame_mode_e;

  // ------------------------------
  // length counter load table
  // ------------------------------

  localparam logic [7:0] LENGTH_TABLE [32] = '{
    8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
  };

  // maps the 5-bit index written to a length register to its count.
  function automatic logic [7:0] length_lookup(input logic [4:0] index);
    return LENGTH_TABLE[index];
  endfunction

endpackage : apu_pkg

// File: noise/noise_channel.sv
`timescale 1ns/100ps
`include "apu_consts.svh"

module noise_channel (
  input  logic       clk,
  input  logic       rst_l,
  apu_bus_if.chan    bus,
  input  logic       enable,
  output logic       length_non_zero,
  output logic [3:0] level
);

  localparam logic [11:0] PERIOD_TABLE [16] = '{
    12'd4,   12'd8,   12'd16,  12'd32,  12'd64,  12'd96,   12'd128,  12'd160,
    12'd202, 12'd254, 12'd380, 12'd508, 12'd762, 12'd1016, 12'd2034, 12'd4068
  };

  logic        loop_halt, const_vol, mode;
  logic [3:0]  vol, period_index;
  logic [11:0] timer;
  logic [14:0] lfsr;
  logic        feedback;
  logic [3:0]  env_level;
  logic        wr_ok, wr0, wr2, wr3;

  assign wr_ok = bus.we & bus.cpu_clk_en;
  assign wr0   = wr_ok & (bus.addr == `APU_NOISE_BASE);
  assign wr2   = wr_ok & (bus.addr == `APU_NOISE_BASE + 16'd2);
  assign wr3   = wr_ok & (bus.addr == `APU_NOISE_BASE + 16'd3);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      loop_halt    <= 1'b0;
      const_vol    <= 1'b0;
      vol          <= '0;
      mode         <= 1'b0;
      period_index <= '0;
    end else begin
      if (wr0) begin
        loop_halt <= bus.data[5];
        const_vol <= bus.data[4];
        vol       <= bus.data[3:0];
      end
      if (wr2) begin
        mode         <= bus.data[7];
        period_index <= bus.data[3:0];
      end
    end
  end

  // mode 1 taps bit 6 for the short, metallic sequence.
  assign feedback = lfsr[0] ^ (mode ? lfsr[6] : lfsr[1]);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      timer <= '0;
      lfsr  <= 15'd1;
    end else if (bus.apu_clk_en) begin
      if (timer == 12'd0) begin
        timer <= PERIOD_TABLE[period_index];
        lfsr  <= {feedback, lfsr[14:1]};
      end else begin
        timer <= timer - 12'd1;
      end
    end
  end

  envelope i_env (
    .clk, .rst_l, .quarter_tick(bus.quarter_tick), .start(wr3),
    .loop_flag(loop_halt), .const_vol, .vol, .level(env_level));

  length_counter i_len (
    .clk, .rst_l, .half_tick(bus.half_tick), .load(wr3), .halt(loop_halt),
    .enable, .load_index(bus.data[7:3]), .non_zero(length_non_zero));

  assign level = (!lfsr[0] && length_non_zero) ? env_level : 4'd0;

endmodule : noise_channel

// File: pulse/pulse_channel.sv
`timescale 1ns/100ps

module pulse_channel #(
  parameter logic [15:0] BASE_ADDR = 16'h4000
) (
  input  logic       clk,
  input  logic       rst_l,
  apu_bus_if.chan    bus,
  input  logic       enable,
  output logic       length_non_zero,
  output logic [3:0] level
);

  import apu_pkg::*;

  duty_e       duty;
  logic        loop_halt, const_vol;
  logic [3:0]  vol;
  logic [10:0] period, timer;
  logic [2:0]  seq;
  logic        duty_bit;
  logic [3:0]  env_level;
  logic        wr_ok, wr0, wr2, wr3;

  // the sweep register at BASE_ADDR + 1 is not decoded.
  assign wr_ok = bus.we & bus.cpu_clk_en;
  assign wr0   = wr_ok & (bus.addr == BASE_ADDR);
  assign wr2   = wr_ok & (bus.addr == BASE_ADDR + 16'd2);
  assign wr3   = wr_ok & (bus.addr == BASE_ADDR + 16'd3);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      duty      <= duty_12;
      loop_halt <= 1'b0;
      const_vol <= 1'b0;
      vol       <= '0;
      period    <= '0;
    end else begin
      if (wr0) begin
        duty      <= duty_e'(bus.data[7:6]);
        loop_halt <= bus.data[5];
        const_vol <= bus.data[4];
        vol       <= bus.data[3:0];
      end
      if (wr2)
        period[7:0] <= bus.data;
      if (wr3)
        period[10:8] <= bus.data[2:0];
    end
  end

  // ------------------------------
  // timer and duty sequencer
  // ------------------------------

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      timer <= '0;
      seq   <= '0;
    end else if (wr3) begin
      seq <= '0; // a length write restarts the waveform.
    end else if (bus.apu_clk_en) begin
      if (timer == 11'd0) begin
        timer <= period;
        seq   <= seq + 3'd1;
      end else begin
        timer <= timer - 11'd1;
      end
    end
  end

  always_comb begin
    unique case (duty)
      duty_12: duty_bit = (seq == 3'd7);
      duty_25: duty_bit = (seq >= 3'd6);
      duty_50: duty_bit = (seq >= 3'd4);
      duty_75: duty_bit = (seq < 3'd6);
    endcase
  end

  envelope i_env (
    .clk, .rst_l, .quarter_tick(bus.quarter_tick), .start(wr3),
    .loop_flag(loop_halt), .const_vol, .vol, .level(env_level));

  length_counter i_len (
    .clk, .rst_l, .half_tick(bus.half_tick), .load(wr3), .halt(loop_halt),
    .enable, .load_index(bus.data[7:3]), .non_zero(length_non_zero));

  // short periods would be ultrasonic and are muted.
  assign level = (duty_bit && length_non_zero && (period >= 11'd8)) ? env_level : 4'd0;

endmodule : pulse_channel

// File: rtl/apu.sv
`timescale 1ns/100ps
`include "apu_consts.svh"

module apu (
  input  logic        clk,
  input  logic        rst_l,
  input  logic        cpu_clk_en,
  input  logic        apu_clk_en,
  input  logic [15:0] direct_addr,
  input  logic [7:0]  direct_data_in,
  input  logic        direct_we,
  input  logic [15:0] reg_addr,
  input  logic        reg_en,
  input  logic        reg_we,
  output logic [7:0]  reg_data_out,
  output logic        irq_l,
  output logic [15:0] audio_out
);

  apu_bus_if bus ();

  logic [3:0] pulse0_level, pulse1_level, noise_level;
  logic [2:0] enables;      // pulse0, pulse1, noise from bit 0 up.
  logic [2:0] length_flags;
  logic       frame_irq, irq_clear;

  assign bus.addr       = direct_addr;
  assign bus.data       = direct_data_in;
  assign bus.we         = direct_we;
  assign bus.cpu_clk_en = cpu_clk_en;
  assign bus.apu_clk_en = apu_clk_en;

  frame_counter i_frame (.clk, .rst_l, .bus(bus.frame), .irq_clear, .frame_irq);

  pulse_channel #(.BASE_ADDR(`APU_PULSE0_BASE)) i_pulse0 (
    .clk, .rst_l, .bus(bus.chan), .enable(enables[0]),
    .length_non_zero(length_flags[0]), .level(pulse0_level));

  pulse_channel #(.BASE_ADDR(`APU_PULSE1_BASE)) i_pulse1 (
    .clk, .rst_l, .bus(bus.chan), .enable(enables[1]),
    .length_non_zero(length_flags[1]), .level(pulse1_level));

  noise_channel i_noise (
    .clk, .rst_l, .bus(bus.chan), .enable(enables[2]),
    .length_non_zero(length_flags[2]), .level(noise_level));

  apu_status i_status (
    .clk, .rst_l, .bus(bus.status), .reg_addr, .reg_en, .reg_we, .frame_irq,
    .length_flags, .enables, .irq_clear, .reg_data_out, .irq_l);

  mixer i_mixer (
    .clk, .rst_l, .pulse0(pulse0_level), .pulse1(pulse1_level),
    .noise(noise_level), .audio_out);

endmodule : apu

// File: rtl/apu_status.sv
`timescale 1ns/100ps
`include "apu_consts.svh"

module apu_status (
  input  logic        clk,
  input  logic        rst_l,
  apu_bus_if.status   bus,
  input  logic [15:0] reg_addr,
  input  logic        reg_en,
  input  logic        reg_we,
  input  logic        frame_irq,
  input  logic [2:0]  length_flags,
  output logic [2:0]  enables,
  output logic        irq_clear,
  output logic [7:0]  reg_data_out,
  output logic        irq_l
);

  logic [2:0] enable_q;
  logic       status_wr, status_rd;

  assign status_wr = bus.we & bus.cpu_clk_en & (bus.addr == `APU_STATUS_ADDR);
  assign status_rd = reg_en & ~reg_we & bus.cpu_clk_en & (reg_addr == `APU_STATUS_ADDR);

  // the new enables reach the length counters on the write edge itself.
  assign enables = status_wr ? bus.data[2:0] : enable_q;

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      enable_q <= '0;
    else
      enable_q <= enables;
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      reg_data_out <= '0;
    else if (status_rd)
      reg_data_out <= {1'b1, frame_irq, 1'b0, 2'b00, length_flags};
  end

  assign irq_clear = status_rd; // reading the status acknowledges the interrupt.
  assign irq_l     = ~frame_irq;

  // a channel switched off shows a clear length flag from the next cycle.
  assert property (@(posedge clk) disable iff (!rst_l)
    status_wr |=> ((length_flags & ~enable_q) == 3'b000));

endmodule : apu_status

// File: rtl/envelope.sv
`timescale 1ns/100ps

module envelope (
  input  logic       clk,
  input  logic       rst_l,
  input  logic       quarter_tick,
  input  logic       start,
  input  logic       loop_flag,
  input  logic       const_vol,
  input  logic [3:0] vol,
  output logic [3:0] level
);

  logic [3:0] divider;
  logic [3:0] decay;

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      divider <= '0;
      decay   <= '0;
    end else if (start) begin
      decay   <= 4'hf;
      divider <= vol;
    end else if (quarter_tick) begin
      if (divider == 4'd0) begin
        divider <= vol; // vol doubles as the decay period.
        if (decay != 4'd0)
          decay <= decay - 4'd1;
        else if (loop_flag)
          decay <= 4'hf;
      end else begin
        divider <= divider - 4'd1;
      end
    end
  end

  assign level = const_vol ? vol : decay;

endmodule : envelope

// File: rtl/frame_counter.sv
`timescale 1ns/100ps
`include "apu_consts.svh"

module frame_counter (
  input  logic           clk,
  input  logic           rst_l,
  apu_bus_if.frame       bus,
  input  logic           irq_clear,
  output logic           frame_irq
);

  import apu_pkg::*;

  logic [14:0] div;
  logic [2:0]  step;
  frame_mode_e mode;
  logic        inhibit;
  logic        frame_wr, step_end, last_step, skip_step;

  assign frame_wr  = bus.we & bus.cpu_clk_en & (bus.addr == `APU_FRAME_ADDR);
  assign step_end  = bus.apu_clk_en & (div == 15'(`APU_FRAME_STEP - 1));
  assign last_step = (mode == mode_4step) ? (step == 3'd3) : (step == 3'd4);
  assign skip_step = (mode == mode_5step) & (step == 3'd3); // 5-step mode has an idle step.

  assign bus.quarter_tick = step_end & ~skip_step;
  assign bus.half_tick    = step_end & ((step == 3'd1) | last_step);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      div     <= '0;
      step    <= '0;
      mode    <= mode_4step;
      inhibit <= 1'b0;
    end else if (frame_wr) begin
      div     <= '0; // a write restarts the sequence.
      step    <= '0;
      mode    <= frame_mode_e'(bus.data[7]);
      inhibit <= bus.data[6];
    end else if (step_end) begin
      div  <= '0;
      step <= last_step ? 3'd0 : step + 3'd1;
    end else if (bus.apu_clk_en) begin
      div <= div + 15'd1;
    end
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      frame_irq <= 1'b0;
    else if (irq_clear || (frame_wr && bus.data[6]))
      frame_irq <= 1'b0;
    else if (step_end && (mode == mode_4step) && (step == 3'd3) && !inhibit)
      frame_irq <= 1'b1;
  end

  // a tick lands on an apu enable and is never two cycles long.
  assert property (@(posedge clk) disable iff (!rst_l)
    bus.quarter_tick |-> bus.apu_clk_en ##1 !bus.quarter_tick);

endmodule : frame_counter

// File: rtl/length_counter.sv
`timescale 1ns/100ps

module length_counter (
  input  logic       clk,
  input  logic       rst_l,
  input  logic       half_tick,
  input  logic       load,
  input  logic       halt,
  input  logic       enable,
  input  logic [4:0] load_index,
  output logic       non_zero
);

  import apu_pkg::*;

  logic [7:0] count;

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      count <= '0;
    else if (!enable)
      count <= '0; // a disabled channel stays silent.
    else if (load)
      count <= length_lookup(load_index);
    else if (half_tick && !halt && (count != 8'd0))
      count <= count - 8'd1;
  end

  assign non_zero = (count != 8'd0);

  assert property (@(posedge clk) disable iff (!rst_l)
    !enable |=> (count == 8'd0));

endmodule : length_counter

// File: rtl/mixer.sv
`timescale 1ns/100ps
`include "apu_consts.svh"

module mixer (
  input  logic        clk,
  input  logic        rst_l,
  input  logic [3:0]  pulse0,
  input  logic [3:0]  pulse1,
  input  logic [3:0]  noise,
  output logic [15:0] audio_out
);

  logic [4:0]  pulse_sum;
  logic [15:0] mix_sum;

  // a linear stand-in for the console's mixing table.
  assign pulse_sum = {1'b0, pulse0} + {1'b0, pulse1};
  assign mix_sum   = 16'(pulse_sum) * 16'(`APU_MIX_PULSE_GAIN)
                   + 16'(noise) * 16'(`APU_MIX_NOISE_GAIN);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      audio_out <= '0;
    else
      audio_out <= mix_sum; // peak is 19200 and fits.
  end

endmodule : mixer

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module apu_tb -f sources.f -o apu_sim

output=$(./obj_dir/apu_sim 2>&1) || true
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
  exit 0
fi
exit 1

// File: sources.f
+incdir+common
common/apu_pkg.sv
common/apu_bus_if.sv
rtl/frame_counter.sv
rtl/envelope.sv
rtl/length_counter.sv
pulse/pulse_channel.sv
noise/noise_channel.sv
rtl/apu_status.sv
rtl/mixer.sv
rtl/apu.sv
tb/apu_tb.sv

// File: tb/apu_tb.sv
`timescale 1ns/100ps
`include "apu_consts.svh"

module apu_tb;

  import apu_pkg::*;

  localparam int FRAME_CYCLES      = 4 * `APU_FRAME_STEP * 2; // apu ticks come every other cycle.
  localparam int HALF_FRAME_CYCLES = 2 * `APU_FRAME_STEP * 2;
  localparam int IRQ_LIMIT         = 5 * `APU_FRAME_STEP * 2;
  localparam int POLL_CYCLES       = 256;

  logic        clk;
  logic        rst_l;
  logic        cpu_clk_en;
  logic        apu_clk_en;
  logic [15:0] direct_addr;
  logic [7:0]  direct_data_in;
  logic        direct_we;
  logic [15:0] reg_addr;
  logic        reg_en;
  logic        reg_we;
  logic [7:0]  reg_data_out;
  logic        irq_l;
  logic [15:0] audio_out;

  logic [15:0] rand_state;
  logic [7:0]  exp_mask, exp_val;   // what the next status read must return.
  logic [3:0]  v0, v1, vn;
  logic        reset_phase, mix_phase, silent_phase, inhibit_phase, chk_ack;
  logic        rd_fire;
  logic        expired;
  int          waited;
  int          expiry_limit;

  apu i_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) apu_clk_en <= ~apu_clk_en;

  assign rd_fire = reg_en && !reg_we && cpu_clk_en && (reg_addr == `APU_STATUS_ADDR);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first failure");
  endtask

  // ------------------------------
  // random numbers
  // ------------------------------

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      rand_state = lfsr_step(rand_state);
      value      = {value[14:0], rand_state[0]};
    end
  endtask

  // every channel is either silent or at its volume, so eight sums are possible.
  function automatic logic mix_allowed(input logic [15:0] sample,
                                       input logic [3:0] p0, p1, nz);
    int  expected;
    logic hit;
    hit = 1'b0;
    for (int c = 0; c < 8; c++) begin
      expected = (c[0] ? int'(p0) : 0) * `APU_MIX_PULSE_GAIN
               + (c[1] ? int'(p1) : 0) * `APU_MIX_PULSE_GAIN
               + (c[2] ? int'(nz) : 0) * `APU_MIX_NOISE_GAIN;
      if (int'(sample) == expected)
        hit = 1'b1;
    end
    return hit;
  endfunction

  // ------------------------------
  // bus tasks
  // ------------------------------

  task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk);
    direct_addr    <= addr;
    direct_data_in <= data;
    direct_we      <= 1'b1;
    @(posedge clk);
    direct_we      <= 1'b0;
  endtask

  // bit 7 always reads 1 and bits 5 to 3 always read 0.
  task automatic read_status(input logic [7:0] mask, input logic [7:0] value);
    @(posedge clk);
    exp_mask <= mask | 8'hB8;
    exp_val  <= value | 8'h80;
    reg_addr <= `APU_STATUS_ADDR;
    reg_we   <= 1'b0;
    reg_en   <= 1'b1;
    @(posedge clk);
    reg_en   <= 1'b0;
    @(posedge clk);
  endtask

  task automatic program_pulse(input logic [15:0] base, output logic [3:0] vol);
    logic [15:0] r;
    take_bits(4, r);
    vol = r[3:0];
    take_bits(2, r);
    write_reg(base, {duty_e'(r[1:0]), 2'b11, vol}); // halted, constant volume.
    take_bits(8, r);
    write_reg(base + 16'd2, r[7:0] | 8'h08);
    take_bits(8, r);
    write_reg(base + 16'd3, r[7:0]);
  endtask

  task automatic program_noise(output logic [3:0] vol);
    logic [15:0] r;
    take_bits(4, r);
    vol = r[3:0];
    write_reg(`APU_NOISE_BASE, {2'b00, 2'b11, vol});
    take_bits(5, r);
    write_reg(`APU_NOISE_BASE + 16'd2, {r[4], 3'b000, r[3:0]});
    take_bits(5, r);
    write_reg(`APU_NOISE_BASE + 16'd3, {r[4:0], 3'b000});
  endtask

  // ------------------------------
  // checks
  // ------------------------------

  assert property (@(posedge clk) disable iff (!rst_l)
    reset_phase |-> (irq_l && (audio_out == 16'h0)))
  else report_failure($sformatf("ERROR irq_l 0x%h audio_out 0x%h after reset, expected 0x1 0x0000",
    $sampled(irq_l), $sampled(audio_out)));

  assert property (@(posedge clk) disable iff (!rst_l)
    rd_fire |=> ((reg_data_out & exp_mask) == exp_val))
  else report_failure($sformatf("ERROR reg_data_out 0x%h, expected 0x%h under mask 0x%h",
    $sampled(reg_data_out), exp_val, exp_mask));

  assert property (@(posedge clk) disable iff (!rst_l)
    $past(rd_fire && chk_ack, 2) |-> irq_l)
  else report_failure($sformatf("ERROR irq_l 0x%h two cycles after a status read, expected 0x1",
    $sampled(irq_l)));

  assert property (@(posedge clk) disable iff (!rst_l)
    mix_phase |-> mix_allowed(audio_out, v0, v1, vn))
  else report_failure($sformatf("ERROR audio_out 0x%h is no sum of volumes 0x%h 0x%h 0x%h",
    $sampled(audio_out), v0, v1, vn));

  assert property (@(posedge clk) disable iff (!rst_l)
    silent_phase |-> (audio_out == 16'h0))
  else report_failure($sformatf("ERROR audio_out 0x%h with all channels off, expected 0x0000",
    $sampled(audio_out)));

  assert property (@(posedge clk) disable iff (!rst_l)
    inhibit_phase |-> irq_l)
  else report_failure($sformatf("ERROR irq_l 0x%h with the interrupt inhibited, expected 0x1",
    $sampled(irq_l)));

  initial begin
    clk            = 1'b0;
    rst_l          = 1'b0;
    cpu_clk_en     = 1'b1;
    apu_clk_en     = 1'b0;
    direct_addr    = '0;
    direct_data_in = '0;
    direct_we      = 1'b0;
    reg_addr       = '0;
    reg_en         = 1'b0;
    reg_we         = 1'b0;
    rand_state     = 16'd40;
    exp_mask       = '0;
    exp_val        = '0;
    {v0, v1, vn}   = '0;
    {reset_phase, mix_phase, silent_phase, inhibit_phase, chk_ack} = '0;
    repeat (5) @(posedge clk);
    rst_l <= 1'b1;

    @(posedge clk);
    reset_phase <= 1'b1;
    repeat (8) @(posedge clk);
    read_status(8'hFF, 8'h80);
    reset_phase <= 1'b0;

    // all three channels on at constant volume.
    write_reg(`APU_STATUS_ADDR, 8'h07);
    program_pulse(`APU_PULSE0_BASE, v0);
    program_pulse(`APU_PULSE1_BASE, v1);
    program_noise(vn);
    repeat (2) @(posedge clk);
    mix_phase <= 1'b1;
    repeat (4000) @(posedge clk);
    read_status(8'h07, 8'h07);
    write_reg(`APU_STATUS_ADDR, 8'h06);
    read_status(8'h07, 8'h06);
    write_reg(`APU_STATUS_ADDR, 8'h00);
    @(posedge clk);
    silent_phase <= 1'b1;
    repeat (200) @(posedge clk);
    read_status(8'h07, 8'h00);
    silent_phase <= 1'b0;
    mix_phase    <= 1'b0;

    // frame interrupt in 4-step mode.
    write_reg(`APU_FRAME_ADDR, {mode_4step, 1'b0, 6'b000000});
    waited = 0;
    while (irq_l && (waited < IRQ_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    if (irq_l)
      report_failure("irq_l did not fall in 4-step mode within five frame steps");
    chk_ack <= 1'b1;
    read_status(8'h40, 8'h40);
    repeat (2) @(posedge clk);
    chk_ack <= 1'b0;

    write_reg(`APU_FRAME_ADDR, {mode_4step, 1'b1, 6'b000000});
    @(posedge clk);
    inhibit_phase <= 1'b1;
    repeat (FRAME_CYCLES + 64) @(posedge clk);

    // noise with the length counter running from index 0.
    write_reg(`APU_STATUS_ADDR, 8'h04);
    write_reg(`APU_NOISE_BASE, 8'h1F);
    write_reg(`APU_NOISE_BASE + 16'd3, 8'h00);
    read_status(8'h04, 8'h04);
    expiry_limit = (int'(length_lookup(5'd0)) + 2) * HALF_FRAME_CYCLES;
    waited  = 0;
    expired = 1'b0;
    while (!expired && (waited < expiry_limit)) begin
      read_status(8'h00, 8'h00);
      expired = !reg_data_out[2];
      repeat (POLL_CYCLES) @(posedge clk);
      waited += POLL_CYCLES + 3;
    end
    if (!expired)
      report_failure("noise length counter did not expire within its half-frame count");
    read_status(8'h04, 8'h00);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule : apu_tb
